// File: hw/retire_params.svh
`ifndef RETIRE_PARAMS_SVH
`define RETIRE_PARAMS_SVH

// implemented csr numbers
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_BADV    14'h007
`define CSR_EENTRY  14'h00c
`define CSR_SAVE0   14'h030
`define CSR_SAVE1   14'h031
`define CSR_SAVE2   14'h032
`define CSR_SAVE3   14'h033

// software-writable bits per csr
`define CRMD_WMASK   32'h0000_0007
`define PRMD_WMASK   32'h0000_0007
`define ESTAT_WMASK  32'h0000_0003
`define EENTRY_WMASK 32'hffff_ffc0
`define FULL_WMASK   32'hffff_ffff

// reset values with da set in crmd
`define CRMD_RESET   32'h0000_0008
`define CSR_RESET    32'h0000_0000

// codes that also load badv
`define ECODE_ADEF   6'h08
`define ECODE_ALE    6'h09

// field positions
`define PLV_IE_MSB          2
`define ESTAT_ECODE_MSB     21
`define ESTAT_ECODE_LSB     16
`define ESTAT_ESUBCODE_MSB  30
`define ESTAT_ESUBCODE_LSB  22

`endif

// File: hw/retire_pkg.sv
package retire_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // general register number
    typedef logic [4:0] reg_addr_t;

    // csr number as carried by csrrd/csrwr/csrxchg
    typedef logic [13:0] csr_num_t;

    // exception code and subcode as recorded in estat
    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

endpackage

// File: hw/reg_file.sv
module reg_file
    import retire_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,

    input  reg_addr_t raddr1,
    output word_t     rdata1,
    input  reg_addr_t raddr2,
    output word_t     rdata2
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads zero regardless of array contents
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: hw/csr_file.sv
`include "retire_params.svh"

module csr_file
    import retire_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  csr_num_t  csr_num,
    input  logic      csr_we,
    input  word_t     csr_wmask,
    input  word_t     csr_wvalue,

    input  logic      ex_commit,
    input  logic      ertn_commit,
    input  word_t     ex_pc,
    input  ecode_t    ex_ecode,
    input  esubcode_t ex_esubcode,
    input  word_t     ex_bad_addr,

    output word_t     csr_rvalue,
    output word_t     csr_eentry,
    output word_t     csr_era
);

    localparam csr_num_t SAVE_NUM [4] = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3};

    word_t crmd;
    word_t prmd;
    word_t estat;
    word_t era;
    word_t badv;
    word_t eentry;
    word_t save [4];

    logic badv_load;

    // per-bit merge of new and old value
    function automatic word_t merge(input word_t old_value, input word_t new_value,
                                    input word_t mask);
        return (new_value & mask) | (old_value & ~mask);
    endfunction

    assign badv_load = ex_commit && (ex_ecode == `ECODE_ADEF || ex_ecode == `ECODE_ALE);

    // exception clears plv and ie and ertn restores them from prmd
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= `CRMD_RESET;
        end else if (ex_commit) begin
            crmd[`PLV_IE_MSB:0] <= '0;
        end else if (ertn_commit) begin
            crmd[`PLV_IE_MSB:0] <= prmd[`PLV_IE_MSB:0];
        end else if (csr_we && csr_num == `CSR_CRMD) begin
            crmd <= merge(crmd, csr_wvalue, csr_wmask & `CRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd <= `CSR_RESET;
        end else if (ex_commit) begin
            prmd[`PLV_IE_MSB:0] <= crmd[`PLV_IE_MSB:0];
        end else if (csr_we && csr_num == `CSR_PRMD) begin
            prmd <= merge(prmd, csr_wvalue, csr_wmask & `PRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat <= `CSR_RESET;
        end else if (ex_commit) begin
            estat[`ESTAT_ECODE_MSB:`ESTAT_ECODE_LSB]       <= ex_ecode;
            estat[`ESTAT_ESUBCODE_MSB:`ESTAT_ESUBCODE_LSB] <= ex_esubcode;
        end else if (csr_we && csr_num == `CSR_ESTAT) begin
            estat <= merge(estat, csr_wvalue, csr_wmask & `ESTAT_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            era <= `CSR_RESET;
        end else if (ex_commit) begin
            era <= ex_pc;
        end else if (csr_we && csr_num == `CSR_ERA) begin
            era <= merge(era, csr_wvalue, csr_wmask & `FULL_WMASK);
        end
    end

    // only address faults record badv
    always_ff @(posedge clk) begin
        if (reset) begin
            badv <= `CSR_RESET;
        end else if (badv_load) begin
            badv <= ex_bad_addr;
        end else if (csr_we && csr_num == `CSR_BADV) begin
            badv <= merge(badv, csr_wvalue, csr_wmask & `FULL_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            eentry <= `CSR_RESET;
        end else if (csr_we && csr_num == `CSR_EENTRY) begin
            eentry <= merge(eentry, csr_wvalue, csr_wmask & `EENTRY_WMASK);
        end
    end

    for (genvar i = 0; i < 4; i++) begin : g_save
        always_ff @(posedge clk) begin
            if (reset) begin
                save[i] <= `CSR_RESET;
            end else if (csr_we && csr_num == SAVE_NUM[i]) begin
                save[i] <= merge(save[i], csr_wvalue, csr_wmask & `FULL_WMASK);
            end
        end
    end

    always_comb begin
        case (csr_num)
            `CSR_CRMD:   csr_rvalue = crmd;
            `CSR_PRMD:   csr_rvalue = prmd;
            `CSR_ESTAT:  csr_rvalue = estat;
            `CSR_ERA:    csr_rvalue = era;
            `CSR_BADV:   csr_rvalue = badv;
            `CSR_EENTRY: csr_rvalue = eentry;
            `CSR_SAVE0:  csr_rvalue = save[0];
            `CSR_SAVE1:  csr_rvalue = save[1];
            `CSR_SAVE2:  csr_rvalue = save[2];
            `CSR_SAVE3:  csr_rvalue = save[3];
            // unimplemented numbers read as zero
            default:     csr_rvalue = '0;
        endcase
    end

    assign csr_eentry = eentry;
    assign csr_era    = era;

endmodule

// File: hw/wb_stage.sv
module wb_stage
    import retire_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      in_valid,
    input  word_t     in_pc,
    input  logic      in_gr_we,
    input  reg_addr_t in_dest,
    input  word_t     in_result,
    input  word_t     in_rkd_value,
    input  logic      in_csr_re,
    input  logic      in_csr_we,
    input  csr_num_t  in_csr_num,
    input  word_t     in_csr_wmask,
    input  logic      in_ex,
    input  ecode_t    in_ecode,
    input  esubcode_t in_esubcode,
    input  word_t     in_bad_addr,
    input  logic      in_ertn,

    input  word_t     csr_rvalue,
    input  word_t     csr_eentry,
    input  word_t     csr_era,

    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata,

    output csr_num_t  csr_num,
    output logic      csr_we,
    output word_t     csr_wmask,
    output word_t     csr_wvalue,
    output logic      ex_commit,
    output logic      ertn_commit,
    output word_t     ex_pc,
    output ecode_t    ex_ecode,
    output esubcode_t ex_esubcode,
    output word_t     ex_bad_addr,

    output logic      flush,
    output word_t     flush_target,

    output word_t     debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_addr_t debug_wb_rf_wnum,
    output word_t     debug_wb_rf_wdata
);

    logic      valid;
    word_t     pc;
    logic      gr_we;
    reg_addr_t dest;
    word_t     result;
    word_t     rkd_value;
    logic      csr_re_q;
    logic      csr_we_q;
    csr_num_t  csr_num_q;
    word_t     csr_wmask_q;
    logic      ex_q;
    ecode_t    ecode_q;
    esubcode_t esubcode_q;
    word_t     bad_addr_q;
    logic      ertn_q;

    // the entry arriving at a flush edge is dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= in_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && !flush) begin
            pc          <= in_pc;
            gr_we       <= in_gr_we;
            dest        <= in_dest;
            result      <= in_result;
            rkd_value   <= in_rkd_value;
            csr_re_q    <= in_csr_re;
            csr_we_q    <= in_csr_we;
            csr_num_q   <= in_csr_num;
            csr_wmask_q <= in_csr_wmask;
            ex_q        <= in_ex;
            ecode_q     <= in_ecode;
            esubcode_q  <= in_esubcode;
            bad_addr_q  <= in_bad_addr;
            ertn_q      <= in_ertn;
        end
    end

    // an exception suppresses every other effect of the entry
    assign ex_commit   = valid && ex_q;
    assign ertn_commit = valid && ertn_q && !ex_q;

    assign rf_we    = valid && gr_we && !ex_q;
    assign rf_waddr = dest;
    assign rf_wdata = csr_re_q ? csr_rvalue : result;

    assign csr_num     = csr_num_q;
    assign csr_we      = valid && csr_we_q && !ex_q;
    assign csr_wmask   = csr_wmask_q;
    assign csr_wvalue  = rkd_value;
    assign ex_pc       = pc;
    assign ex_ecode    = ecode_q;
    assign ex_esubcode = esubcode_q;
    assign ex_bad_addr = bad_addr_q;

    assign flush        = ex_commit || ertn_commit;
    assign flush_target = ex_q ? csr_eentry : csr_era;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// File: hw/retire_top.sv
module retire_top
    import retire_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       in_valid,
    input  word_t      in_pc,
    input  logic       in_gr_we,
    input  reg_addr_t  in_dest,
    input  word_t      in_result,
    input  word_t      in_rkd_value,
    input  logic       in_csr_re,
    input  logic       in_csr_we,
    input  csr_num_t   in_csr_num,
    input  word_t      in_csr_wmask,
    input  logic       in_ex,
    input  ecode_t     in_ecode,
    input  esubcode_t  in_esubcode,
    input  word_t      in_bad_addr,
    input  logic       in_ertn,

    input  reg_addr_t  rf_raddr1,
    output word_t      rf_rdata1,
    input  reg_addr_t  rf_raddr2,
    output word_t      rf_rdata2,

    output logic       flush,
    output word_t      flush_target,

    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_addr_t  debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    csr_num_t  csr_num;
    logic      csr_we;
    word_t     csr_wmask;
    word_t     csr_wvalue;
    word_t     csr_rvalue;
    word_t     csr_eentry;
    word_t     csr_era;

    logic      ex_commit;
    logic      ertn_commit;
    word_t     ex_pc;
    ecode_t    ex_ecode;
    esubcode_t ex_esubcode;
    word_t     ex_bad_addr;

    wb_stage u_wb_stage (
        .clk               (clk),
        .reset             (reset),
        .in_valid          (in_valid),
        .in_pc             (in_pc),
        .in_gr_we          (in_gr_we),
        .in_dest           (in_dest),
        .in_result         (in_result),
        .in_rkd_value      (in_rkd_value),
        .in_csr_re         (in_csr_re),
        .in_csr_we         (in_csr_we),
        .in_csr_num        (in_csr_num),
        .in_csr_wmask      (in_csr_wmask),
        .in_ex             (in_ex),
        .in_ecode          (in_ecode),
        .in_esubcode       (in_esubcode),
        .in_bad_addr       (in_bad_addr),
        .in_ertn           (in_ertn),
        .csr_rvalue        (csr_rvalue),
        .csr_eentry        (csr_eentry),
        .csr_era           (csr_era),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .csr_num           (csr_num),
        .csr_we            (csr_we),
        .csr_wmask         (csr_wmask),
        .csr_wvalue        (csr_wvalue),
        .ex_commit         (ex_commit),
        .ertn_commit       (ertn_commit),
        .ex_pc             (ex_pc),
        .ex_ecode          (ex_ecode),
        .ex_esubcode       (ex_esubcode),
        .ex_bad_addr       (ex_bad_addr),
        .flush             (flush),
        .flush_target      (flush_target),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    csr_file u_csr_file (
        .clk         (clk),
        .reset       (reset),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .ex_commit   (ex_commit),
        .ertn_commit (ertn_commit),
        .ex_pc       (ex_pc),
        .ex_ecode    (ex_ecode),
        .ex_esubcode (ex_esubcode),
        .ex_bad_addr (ex_bad_addr),
        .csr_rvalue  (csr_rvalue),
        .csr_eentry  (csr_eentry),
        .csr_era     (csr_era)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rf_raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (rf_raddr2),
        .rdata2 (rf_rdata2)
    );

endmodule

// File: bench/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: bench/tb_retire.sv
`include "retire_params.svh"

module tb_retire
    import retire_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CYCLES    = 2000;
    localparam int RESET_TIMEOUT = 40;

    logic       clk;
    logic       reset;
    logic       in_valid;
    word_t      in_pc;
    logic       in_gr_we;
    reg_addr_t  in_dest;
    word_t      in_result;
    word_t      in_rkd_value;
    logic       in_csr_re;
    logic       in_csr_we;
    csr_num_t   in_csr_num;
    word_t      in_csr_wmask;
    logic       in_ex;
    ecode_t     in_ecode;
    esubcode_t  in_esubcode;
    word_t      in_bad_addr;
    logic       in_ertn;
    reg_addr_t  rf_raddr1;
    word_t      rf_rdata1;
    reg_addr_t  rf_raddr2;
    word_t      rf_rdata2;
    logic       flush;
    word_t      flush_target;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    logic [15:0] lfsr = 16'd39;

    // reference state
    word_t m_regs [32];
    word_t m_crmd;
    word_t m_prmd;
    word_t m_estat;
    word_t m_era;
    word_t m_badv;
    word_t m_eentry;
    word_t m_save [4];

    // entry sitting in writeback
    logic      h_valid;
    word_t     h_pc;
    logic      h_gr_we;
    reg_addr_t h_dest;
    word_t     h_result;
    word_t     h_rkd;
    logic      h_csr_re;
    logic      h_csr_we;
    csr_num_t  h_csr_num;
    word_t     h_wmask;
    logic      h_ex;
    ecode_t    h_ecode;
    esubcode_t h_esub;
    word_t     h_bad;
    logic      h_ertn;

    // 0x040 is not implemented
    csr_num_t csr_choices [11] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ESTAT, `CSR_ERA, `CSR_BADV,
                                   `CSR_EENTRY, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2,
                                   `CSR_SAVE3, 14'h040};

    tb_clock u_clock (.clk(clk), .reset(reset));

    retire_top dut (.*);

    // x^16 + x^14 + x^13 + x^11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic word_t model_csr(input csr_num_t num);
        case (num)
            `CSR_CRMD:   return m_crmd;
            `CSR_PRMD:   return m_prmd;
            `CSR_ESTAT:  return m_estat;
            `CSR_ERA:    return m_era;
            `CSR_BADV:   return m_badv;
            `CSR_EENTRY: return m_eentry;
            `CSR_SAVE0:  return m_save[0];
            `CSR_SAVE1:  return m_save[1];
            `CSR_SAVE2:  return m_save[2];
            `CSR_SAVE3:  return m_save[3];
            default:     return '0;
        endcase
    endfunction

    // flip only the bits that differ and are inside both masks
    task automatic write_csr(input csr_num_t num, input word_t value, input word_t mask);
        case (num)
            `CSR_CRMD:   m_crmd   = m_crmd ^ ((m_crmd ^ value) & mask & `CRMD_WMASK);
            `CSR_PRMD:   m_prmd   = m_prmd ^ ((m_prmd ^ value) & mask & `PRMD_WMASK);
            `CSR_ESTAT:  m_estat  = m_estat ^ ((m_estat ^ value) & mask & `ESTAT_WMASK);
            `CSR_ERA:    m_era    = m_era ^ ((m_era ^ value) & mask);
            `CSR_BADV:   m_badv   = m_badv ^ ((m_badv ^ value) & mask);
            `CSR_EENTRY: m_eentry = m_eentry ^ ((m_eentry ^ value) & mask & `EENTRY_WMASK);
            `CSR_SAVE0:  m_save[0] = m_save[0] ^ ((m_save[0] ^ value) & mask);
            `CSR_SAVE1:  m_save[1] = m_save[1] ^ ((m_save[1] ^ value) & mask);
            `CSR_SAVE2:  m_save[2] = m_save[2] ^ ((m_save[2] ^ value) & mask);
            `CSR_SAVE3:  m_save[3] = m_save[3] ^ ((m_save[3] ^ value) & mask);
            default:     ;
        endcase
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (reset && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (reset) begin
            fail_run("timeout: reset was never released");
        end
    endtask

    // retire the held entry at this edge, then take the offered one
    task automatic retire_model();
        logic  flush_now;
        word_t wdata;
        word_t old_crmd;
        flush_now = h_valid && (h_ex || h_ertn);
        if (h_valid) begin
            wdata    = h_csr_re ? model_csr(h_csr_num) : h_result;
            old_crmd = m_crmd;
            if (h_ex) begin
                m_prmd[2:0]    = old_crmd[2:0];
                m_crmd[2:0]    = 3'b000;
                m_estat[21:16] = h_ecode;
                m_estat[30:22] = h_esub;
                m_era          = h_pc;
                if (h_ecode == `ECODE_ADEF || h_ecode == `ECODE_ALE) begin
                    m_badv = h_bad;
                end
            end else begin
                if (h_gr_we && h_dest != 5'd0) begin
                    m_regs[h_dest] = wdata;
                end
                if (h_csr_we) begin
                    write_csr(h_csr_num, h_rkd, h_wmask);
                end
                if (h_ertn) begin
                    m_crmd[2:0] = m_prmd[2:0];
                end
            end
        end
        h_valid = in_valid && !flush_now;
        if (h_valid) begin
            h_pc      = in_pc;
            h_gr_we   = in_gr_we;
            h_dest    = in_dest;
            h_result  = in_result;
            h_rkd     = in_rkd_value;
            h_csr_re  = in_csr_re;
            h_csr_we  = in_csr_we;
            h_csr_num = in_csr_num;
            h_wmask   = in_csr_wmask;
            h_ex      = in_ex;
            h_ecode   = in_ecode;
            h_esub    = in_esubcode;
            h_bad     = in_bad_addr;
            h_ertn    = in_ertn;
        end
    endtask

    task automatic drive_entry();
        logic        ertn;
        logic [1:0]  sel;
        ertn = (rand_bits(4) == 1);
        sel  = 2'(rand_bits(2));
        in_valid     <= (rand_bits(2) != 0);
        in_pc        <= rand_bits(32) & 32'hffff_fffc;
        in_gr_we     <= lfsr_step();
        in_dest      <= reg_addr_t'(rand_bits(5));
        in_result    <= rand_bits(32);
        in_rkd_value <= rand_bits(32);
        in_csr_re    <= lfsr_step();
        // ertn never carries a csr write
        in_csr_we    <= ertn ? 1'b0 : lfsr_step();
        in_csr_num   <= csr_choices[rand_bits(4) % 11];
        in_csr_wmask <= rand_bits(32);
        in_ex        <= (rand_bits(4) == 0);
        in_ecode     <= (sel == 0) ? `ECODE_ADEF : (sel == 1) ? `ECODE_ALE : ecode_t'(rand_bits(6));
        in_esubcode  <= esubcode_t'(rand_bits(9));
        in_bad_addr  <= rand_bits(32);
        in_ertn      <= ertn;
        rf_raddr1    <= reg_addr_t'(rand_bits(5));
        rf_raddr2    <= reg_addr_t'(rand_bits(5));
    endtask

    task automatic check_outputs();
        logic exp_we;
        logic exp_flush;
        exp_we    = h_valid && h_gr_we && !h_ex;
        exp_flush = h_valid && (h_ex || h_ertn);
        check_bit("flush", flush, exp_flush);
        check_word("debug_wb_rf_we", word_t'(debug_wb_rf_we), exp_we ? 32'hf : 32'h0);
        if (h_valid) begin
            check_word("debug_wb_pc", debug_wb_pc, h_pc);
            check_addr("debug_wb_rf_wnum", debug_wb_rf_wnum, h_dest);
            check_word("debug_wb_rf_wdata", debug_wb_rf_wdata,
                       h_csr_re ? model_csr(h_csr_num) : h_result);
        end
        if (exp_flush) begin
            check_word("flush_target", flush_target, h_ex ? m_eentry : m_era);
        end
        check_word("rf_rdata1", rf_rdata1, m_regs[rf_raddr1]);
        check_word("rf_rdata2", rf_rdata2, m_regs[rf_raddr2]);
    endtask

    initial begin
        in_valid     = 1'b0;
        in_pc        = '0;
        in_gr_we     = 1'b0;
        in_dest      = '0;
        in_result    = '0;
        in_rkd_value = '0;
        in_csr_re    = 1'b0;
        in_csr_we    = 1'b0;
        in_csr_num   = '0;
        in_csr_wmask = '0;
        in_ex        = 1'b0;
        in_ecode     = '0;
        in_esubcode  = '0;
        in_bad_addr  = '0;
        in_ertn      = 1'b0;
        rf_raddr1    = '0;
        rf_raddr2    = '0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            m_save[i] = '0;
        end
        m_crmd   = `CRMD_RESET;
        m_prmd   = '0;
        m_estat  = '0;
        m_era    = '0;
        m_badv   = '0;
        m_eentry = '0;
        h_valid  = 1'b0;

        wait_reset_release();
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            retire_model();
            drive_entry();
            @(negedge clk);
            check_outputs();
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: sources.f
+incdir+hw
hw/retire_pkg.sv
hw/reg_file.sv
hw/csr_file.sv
hw/wb_stage.sv
hw/retire_top.sv
bench/tb_clock.sv
bench/tb_retire.sv

// File: Bender.yml
package:
  name: retire

sources:
  - include_dirs:
      - hw
    files:
      - hw/retire_pkg.sv
      - hw/reg_file.sv
      - hw/csr_file.sv
      - hw/wb_stage.sv
      - hw/retire_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_clock.sv
      - bench/tb_retire.sv
